//--- logic/dsp_consts.svh
`ifndef DSP_CONSTS_SVH
`define DSP_CONSTS_SVH

// Stream geometry
`define DSP_LANES       4
`define DSP_CODE_W      8

// FFE and slicer
`define DSP_W_W         8
`define DSP_FFE_TAPS    3
`define DSP_EST_W       12
`define DSP_SHIFT_W     4

// Channel estimate and error
`define DSP_H_W         8
`define DSP_CHAN_TAPS   2
`define DSP_ERR_W       12
`define DSP_CNT_W       16

// AXI4-Lite bus
`define DSP_AXIL_ADDR_W 6
`define DSP_AXIL_DATA_W 32

// Register byte offsets
`define DSP_ADDR_W0         6'h00
`define DSP_ADDR_W1         6'h04
`define DSP_ADDR_W2         6'h08
`define DSP_ADDR_FFE_SHIFT  6'h0C
`define DSP_ADDR_THRESH     6'h10
`define DSP_ADDR_H0         6'h14
`define DSP_ADDR_H1         6'h18
`define DSP_ADDR_CHAN_SHIFT 6'h1C
`define DSP_ADDR_FLIP_CNT   6'h20

`endif

//--- logic/dsp_pkg.sv
`include "dsp_consts.svh"

package dsp_pkg;

    // Lane 0 holds the earliest symbol of the word
    typedef logic [`DSP_LANES-1:0][`DSP_CODE_W-1:0] lane_codes_t;
    typedef logic [`DSP_LANES-1:0]                  lane_bits_t;
    typedef logic [`DSP_LANES-1:0][`DSP_ERR_W-1:0]  lane_err_t;

    // Shared by all lanes and held as two's complement
    typedef struct packed {
        logic [`DSP_FFE_TAPS-1:0][`DSP_W_W-1:0]  weights;
        logic [`DSP_SHIFT_W-1:0]                 ffe_shift;
        logic [`DSP_EST_W-1:0]                   thresh;
        logic [`DSP_CHAN_TAPS-1:0][`DSP_H_W-1:0] h;
        logic [`DSP_SHIFT_W-1:0]                 chan_shift;
    } dsp_cfg_t;

    typedef struct packed {
        logic                        awvalid;
        logic [`DSP_AXIL_ADDR_W-1:0] awaddr;
        logic                        wvalid;
        logic [`DSP_AXIL_DATA_W-1:0] wdata;
        logic                        bready;
        logic                        arvalid;
        logic [`DSP_AXIL_ADDR_W-1:0] araddr;
        logic                        rready;
    } axil_req_t;

    typedef struct packed {
        logic                        awready;
        logic                        wready;
        logic                        bvalid;
        logic                        arready;
        logic                        rvalid;
        logic [`DSP_AXIL_DATA_W-1:0] rdata;
    } axil_rsp_t;

    typedef enum logic [1:0] {
        AXS_IDLE,
        AXS_WRESP,
        AXS_RRESP
    } axil_state_e;

    typedef enum logic [`DSP_AXIL_ADDR_W-1:0] {
        REG_W0         = `DSP_ADDR_W0,
        REG_W1         = `DSP_ADDR_W1,
        REG_W2         = `DSP_ADDR_W2,
        REG_FFE_SHIFT  = `DSP_ADDR_FFE_SHIFT,
        REG_THRESH     = `DSP_ADDR_THRESH,
        REG_H0         = `DSP_ADDR_H0,
        REG_H1         = `DSP_ADDR_H1,
        REG_CHAN_SHIFT = `DSP_ADDR_CHAN_SHIFT,
        REG_FLIP_CNT   = `DSP_ADDR_FLIP_CNT
    } cfg_reg_e;

endpackage

//--- logic/cfg_axil_slave.sv
`timescale 1ns/1ps
`include "dsp_consts.svh"

module cfg_axil_slave (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  dsp_pkg::axil_req_t    axil_req_i,
    output dsp_pkg::axil_rsp_t    axil_rsp_o,
    input  logic [`DSP_CNT_W-1:0] flip_count_i,
    output dsp_pkg::dsp_cfg_t     cfg_o,
    output logic                  cnt_clear_o
);
    import dsp_pkg::*;

    // Main taps at one and all other fields zero
    localparam dsp_cfg_t CFG_RESET = '{
        weights:    24'h00_0001,
        ffe_shift:  '0,
        thresh:     '0,
        h:          16'h0001,
        chan_shift: '0
    };

    axil_state_e                 state_q;
    axil_state_e                 state_d;
    dsp_cfg_t                    cfg_q;
    logic [`DSP_AXIL_DATA_W-1:0] rdata_q;
    logic [`DSP_AXIL_DATA_W-1:0] rdata_d;
    logic                        wr_pend;
    logic                        wr_fire;
    logic                        rd_fire;
    cfg_reg_e                    waddr;
    cfg_reg_e                    raddr;

    // A write needs both channels at once, and beats a read in the same cycle
    assign wr_pend = axil_req_i.awvalid | axil_req_i.wvalid;
    assign wr_fire = (state_q == AXS_IDLE) && axil_req_i.awvalid && axil_req_i.wvalid;
    assign rd_fire = (state_q == AXS_IDLE) && !wr_pend && axil_req_i.arvalid;

    assign waddr = cfg_reg_e'(axil_req_i.awaddr);
    assign raddr = cfg_reg_e'(axil_req_i.araddr);

    assign cnt_clear_o = wr_fire && (waddr == REG_FLIP_CNT);
    assign cfg_o       = cfg_q;

    always_comb begin
        axil_rsp_o.awready = wr_fire;
        axil_rsp_o.wready  = wr_fire;
        axil_rsp_o.bvalid  = (state_q == AXS_WRESP);
        axil_rsp_o.arready = (state_q == AXS_IDLE) && !wr_pend;
        axil_rsp_o.rvalid  = (state_q == AXS_RRESP);
        axil_rsp_o.rdata   = rdata_q;
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            AXS_IDLE: begin
                if (wr_fire) begin
                    state_d = AXS_WRESP;
                end else if (rd_fire) begin
                    state_d = AXS_RRESP;
                end
            end
            AXS_WRESP: begin
                if (axil_req_i.bready) begin
                    state_d = AXS_IDLE;
                end
            end
            AXS_RRESP: begin
                if (axil_req_i.rready) begin
                    state_d = AXS_IDLE;
                end
            end
            default: state_d = AXS_IDLE;
        endcase
    end

    // Fields read back zero extended
    always_comb begin
        rdata_d = '0;
        case (raddr)
            REG_W0:         rdata_d[`DSP_W_W-1:0]     = cfg_q.weights[0];
            REG_W1:         rdata_d[`DSP_W_W-1:0]     = cfg_q.weights[1];
            REG_W2:         rdata_d[`DSP_W_W-1:0]     = cfg_q.weights[2];
            REG_FFE_SHIFT:  rdata_d[`DSP_SHIFT_W-1:0] = cfg_q.ffe_shift;
            REG_THRESH:     rdata_d[`DSP_EST_W-1:0]   = cfg_q.thresh;
            REG_H0:         rdata_d[`DSP_H_W-1:0]     = cfg_q.h[0];
            REG_H1:         rdata_d[`DSP_H_W-1:0]     = cfg_q.h[1];
            REG_CHAN_SHIFT: rdata_d[`DSP_SHIFT_W-1:0] = cfg_q.chan_shift;
            REG_FLIP_CNT:   rdata_d[`DSP_CNT_W-1:0]   = flip_count_i;
            default:        rdata_d = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= AXS_IDLE;
            cfg_q   <= CFG_RESET;
        end else begin
            state_q <= state_d;
            if (wr_fire) begin
                case (waddr)
                    REG_W0:         cfg_q.weights[0] <= axil_req_i.wdata[`DSP_W_W-1:0];
                    REG_W1:         cfg_q.weights[1] <= axil_req_i.wdata[`DSP_W_W-1:0];
                    REG_W2:         cfg_q.weights[2] <= axil_req_i.wdata[`DSP_W_W-1:0];
                    REG_FFE_SHIFT:  cfg_q.ffe_shift  <= axil_req_i.wdata[`DSP_SHIFT_W-1:0];
                    REG_THRESH:     cfg_q.thresh     <= axil_req_i.wdata[`DSP_EST_W-1:0];
                    REG_H0:         cfg_q.h[0]       <= axil_req_i.wdata[`DSP_H_W-1:0];
                    REG_H1:         cfg_q.h[1]       <= axil_req_i.wdata[`DSP_H_W-1:0];
                    REG_CHAN_SHIFT: cfg_q.chan_shift <= axil_req_i.wdata[`DSP_SHIFT_W-1:0];
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_fire) begin
            rdata_q <= rdata_d;
        end
    end

endmodule

//--- logic/ffe_slicer.sv
`timescale 1ns/1ps
`include "dsp_consts.svh"

module ffe_slicer (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 codes_valid_i,
    input  dsp_pkg::lane_codes_t codes_i,
    input  dsp_pkg::dsp_cfg_t    cfg_i,
    output logic                 bits_valid_o,
    output dsp_pkg::lane_bits_t  bits_o,
    output dsp_pkg::lane_codes_t codes_d_o
);
    import dsp_pkg::*;

    localparam int HIST  = `DSP_FFE_TAPS - 1;
    localparam int SUM_W = `DSP_CODE_W + `DSP_W_W + 2;

    // Tail of the previous valid word with the oldest symbol at index 0
    logic [HIST-1:0][`DSP_CODE_W-1:0]            hist_q;
    logic [`DSP_LANES+HIST-1:0][`DSP_CODE_W-1:0] seq;
    logic signed [SUM_W-1:0]                     acc     [`DSP_LANES];
    logic signed [SUM_W-1:0]                     acc_sh  [`DSP_LANES];
    logic signed [`DSP_EST_W-1:0]                est     [`DSP_LANES];
    lane_bits_t                                  decide;

    assign seq = {codes_i, hist_q};

    always_comb begin
        for (int k = 0; k < `DSP_LANES; k++) begin
            acc[k] = '0;
            // Tap t multiplies symbol n-t
            for (int t = 0; t < `DSP_FFE_TAPS; t++) begin
                acc[k] = acc[k] + $signed(cfg_i.weights[t]) * $signed(seq[k + HIST - t]);
            end
            acc_sh[k] = acc[k] >>> cfg_i.ffe_shift;
            est[k]    = acc_sh[k][`DSP_EST_W-1:0];
            decide[k] = (est[k] >= $signed(cfg_i.thresh));
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            hist_q       <= '0;
            bits_valid_o <= 1'b0;
        end else begin
            bits_valid_o <= codes_valid_i;
            if (codes_valid_i) begin
                hist_q <= codes_i[`DSP_LANES-1 -: HIST];
            end
        end
    end

    // Codes ride along so later stages see them aligned with the bits
    always_ff @(posedge clk) begin
        if (codes_valid_i) begin
            bits_o    <= decide;
            codes_d_o <= codes_i;
        end
    end

endmodule

//--- logic/channel_error.sv
`timescale 1ns/1ps
`include "dsp_consts.svh"

module channel_error (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 bits_valid_i,
    input  dsp_pkg::lane_bits_t  bits_i,
    input  dsp_pkg::lane_codes_t codes_i,
    input  dsp_pkg::dsp_cfg_t    cfg_i,
    output logic                 err_valid_o,
    output dsp_pkg::lane_err_t   err_o,
    output dsp_pkg::lane_err_t   err_flip_o,
    output dsp_pkg::lane_bits_t  bits_o
);
    import dsp_pkg::*;

    // Room for two full-scale taps of either sign
    localparam int REC_W = `DSP_H_W + 2;

    logic                     bit_prev_q;
    logic [`DSP_LANES:0]      bseq;
    logic signed [REC_W-1:0]  tap1      [`DSP_LANES];
    logic signed [REC_W-1:0]  rec       [`DSP_LANES];
    logic signed [REC_W-1:0]  rec_flip  [`DSP_LANES];
    lane_err_t                err_n;
    lane_err_t                err_flip_n;

    // Bit 1 maps to +h, bit 0 to -h
    function automatic logic signed [REC_W-1:0] signed_tap(
        input logic [`DSP_H_W-1:0] h,
        input logic                b
    );
        logic signed [REC_W-1:0] hx;
        hx = $signed(h);
        return b ? hx : -hx;
    endfunction

    assign bseq = {bits_i, bit_prev_q};

    always_comb begin
        for (int k = 0; k < `DSP_LANES; k++) begin
            tap1[k]     = signed_tap(cfg_i.h[1], bseq[k]);
            rec[k]      = (signed_tap(cfg_i.h[0], bseq[k + 1]) + tap1[k]) >>> cfg_i.chan_shift;
            rec_flip[k] = (signed_tap(cfg_i.h[0], !bseq[k + 1]) + tap1[k])
                          >>> cfg_i.chan_shift;
            err_n[k]      = rec[k] - $signed(codes_i[k]);
            err_flip_n[k] = rec_flip[k] - $signed(codes_i[k]);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            bit_prev_q  <= 1'b0;
            err_valid_o <= 1'b0;
        end else begin
            err_valid_o <= bits_valid_i;
            if (bits_valid_i) begin
                bit_prev_q <= bits_i[`DSP_LANES-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bits_valid_i) begin
            err_o      <= err_n;
            err_flip_o <= err_flip_n;
            bits_o     <= bits_i;
        end
    end

endmodule

//--- logic/error_detector.sv
`timescale 1ns/1ps
`include "dsp_consts.svh"

module error_detector (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                err_valid_i,
    input  dsp_pkg::lane_err_t  err_i,
    input  dsp_pkg::lane_err_t  err_flip_i,
    input  dsp_pkg::lane_bits_t bits_i,
    output logic                bits_valid_o,
    output dsp_pkg::lane_bits_t bits_o,
    output dsp_pkg::lane_bits_t flips_o
);
    import dsp_pkg::*;

    localparam int SQ_W = 2 * `DSP_ERR_W;

    logic [SQ_W-1:0] sq      [`DSP_LANES];
    logic [SQ_W-1:0] sq_flip [`DSP_LANES];
    lane_bits_t      flip_n;

    always_comb begin
        for (int k = 0; k < `DSP_LANES; k++) begin
            sq[k]      = $signed(err_i[k]) * $signed(err_i[k]);
            sq_flip[k] = $signed(err_flip_i[k]) * $signed(err_flip_i[k]);
            // Ties keep the slicer decision
            flip_n[k]  = (sq_flip[k] < sq[k]);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            bits_valid_o <= 1'b0;
        end else begin
            bits_valid_o <= err_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (err_valid_i) begin
            bits_o  <= bits_i ^ flip_n;
            flips_o <= flip_n;
        end
    end

endmodule

//--- logic/flip_counter.sv
`timescale 1ns/1ps
`include "dsp_consts.svh"

module flip_counter (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  flips_valid_i,
    input  dsp_pkg::lane_bits_t   flips_i,
    input  logic                  clear_i,
    output logic [`DSP_CNT_W-1:0] count_o
);
    import dsp_pkg::*;

    localparam int POP_W = $clog2(`DSP_LANES + 1);

    logic [POP_W-1:0]    pop;
    logic [`DSP_CNT_W:0] sum;

    always_comb begin
        pop = '0;
        for (int k = 0; k < `DSP_LANES; k++) begin
            pop = pop + POP_W'(flips_i[k]);
        end
        // Extra MSB catches the wrap
        sum = count_o + pop;
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i || clear_i) begin
            count_o <= '0;
        end else if (flips_valid_i) begin
            count_o <= sum[`DSP_CNT_W] ? '1 : sum[`DSP_CNT_W-1:0];
        end
    end

endmodule

//--- logic/datapath_core.sv
`timescale 1ns/1ps
`include "dsp_consts.svh"

module datapath_core (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 codes_valid_i,
    input  dsp_pkg::lane_codes_t codes_i,
    input  dsp_pkg::axil_req_t   axil_req_i,
    output dsp_pkg::axil_rsp_t   axil_rsp_o,
    output logic                 bits_valid_o,
    output dsp_pkg::lane_bits_t  bits_o,
    output dsp_pkg::lane_bits_t  flips_o
);
    import dsp_pkg::*;

    dsp_cfg_t              cfg;
    logic                  cnt_clear;
    logic [`DSP_CNT_W-1:0] flip_count;

    // Slicer to channel stage
    logic                  slice_valid;
    lane_bits_t            slice_bits;
    lane_codes_t           slice_codes;

    // Channel stage to detector
    logic                  err_valid;
    lane_err_t             err;
    lane_err_t             err_flip;
    lane_bits_t            err_bits;

    cfg_axil_slave cfg_slave_i (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .axil_req_i   (axil_req_i),
        .axil_rsp_o   (axil_rsp_o),
        .flip_count_i (flip_count),
        .cfg_o        (cfg),
        .cnt_clear_o  (cnt_clear)
    );

    ffe_slicer ffe_slicer_i (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .codes_valid_i (codes_valid_i),
        .codes_i       (codes_i),
        .cfg_i         (cfg),
        .bits_valid_o  (slice_valid),
        .bits_o        (slice_bits),
        .codes_d_o     (slice_codes)
    );

    channel_error channel_error_i (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .bits_valid_i (slice_valid),
        .bits_i       (slice_bits),
        .codes_i      (slice_codes),
        .cfg_i        (cfg),
        .err_valid_o  (err_valid),
        .err_o        (err),
        .err_flip_o   (err_flip),
        .bits_o       (err_bits)
    );

    error_detector error_detector_i (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .err_valid_i  (err_valid),
        .err_i        (err),
        .err_flip_i   (err_flip),
        .bits_i       (err_bits),
        .bits_valid_o (bits_valid_o),
        .bits_o       (bits_o),
        .flips_o      (flips_o)
    );

    flip_counter flip_counter_i (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .flips_valid_i (bits_valid_o),
        .flips_i       (flips_o),
        .clear_i       (cnt_clear),
        .count_o       (flip_count)
    );

endmodule

//--- tests/datapath_checker.sv
`timescale 1ns/1ps
`include "dsp_consts.svh"

module datapath_checker (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 codes_valid_i,
    input  dsp_pkg::lane_codes_t codes_i,
    input  dsp_pkg::axil_req_t   axil_req_i,
    input  dsp_pkg::axil_rsp_t   axil_rsp_i,
    input  logic                 bits_valid_i,
    input  dsp_pkg::lane_bits_t  bits_i,
    input  dsp_pkg::lane_bits_t  flips_i,
    output logic                 idle_o,
    output int                   value_errs_o,
    output int                   event_errs_o
);
    import dsp_pkg::*;

    localparam int CNT_MAX = (1 << `DSP_CNT_W) - 1;

    typedef struct packed {
        int         due;
        lane_bits_t bits;
        lane_bits_t flips;
    } exp_word_t;

    exp_word_t   exp_q[$];
    exp_word_t   got;
    logic [31:0] shadow [64];
    int          hist [2];
    logic        bit_prev;
    int          count;
    int          cyc;
    logic [31:0] rd_exp;
    axil_state_e bus_st;
    logic        wr_take;
    logic        rd_free;
    logic        rd_take;

    // Mask of implemented bits per register offset
    function automatic logic [31:0] field_mask(input logic [5:0] addr);
        case (addr)
            `DSP_ADDR_W0, `DSP_ADDR_W1, `DSP_ADDR_W2: return (32'd1 << `DSP_W_W) - 1;
            `DSP_ADDR_H0, `DSP_ADDR_H1:               return (32'd1 << `DSP_H_W) - 1;
            `DSP_ADDR_FFE_SHIFT, `DSP_ADDR_CHAN_SHIFT: return 32'hf;
            `DSP_ADDR_THRESH:                          return (32'd1 << `DSP_EST_W) - 1;
            default:                                   return 32'h0;
        endcase
    endfunction

    // Model of one word through FFE, slicer, channel estimate and flip test
    function automatic exp_word_t predict(input lane_codes_t c);
        exp_word_t                    e;
        int                           seq [6];
        int                           w0;
        int                           w1;
        int                           w2;
        int                           h0;
        int                           h1;
        int                           acc;
        int                           s;
        int                           s_prev;
        int                           err;
        int                           err_f;
        logic signed [`DSP_EST_W-1:0] est;
        logic signed [`DSP_EST_W-1:0] thr;
        w0  = $signed(shadow[`DSP_ADDR_W0][`DSP_W_W-1:0]);
        w1  = $signed(shadow[`DSP_ADDR_W1][`DSP_W_W-1:0]);
        w2  = $signed(shadow[`DSP_ADDR_W2][`DSP_W_W-1:0]);
        h0  = $signed(shadow[`DSP_ADDR_H0][`DSP_H_W-1:0]);
        h1  = $signed(shadow[`DSP_ADDR_H1][`DSP_H_W-1:0]);
        thr = shadow[`DSP_ADDR_THRESH][`DSP_EST_W-1:0];
        seq[0] = hist[0];
        seq[1] = hist[1];
        for (int k = 0; k < `DSP_LANES; k++) begin
            seq[k + 2] = $signed(c[k]);
        end
        s_prev = bit_prev ? 1 : -1;
        e.due  = cyc + 3;
        for (int k = 0; k < `DSP_LANES; k++) begin
            acc = w0 * seq[k + 2] + w1 * seq[k + 1] + w2 * seq[k];
            acc = acc >>> shadow[`DSP_ADDR_FFE_SHIFT][3:0];
            est = acc[`DSP_EST_W-1:0];
            e.bits[k] = (est >= thr);
            s     = e.bits[k] ? 1 : -1;
            err   = ((h0 * s + h1 * s_prev) >>> shadow[`DSP_ADDR_CHAN_SHIFT][3:0]) - seq[k + 2];
            err_f = ((-h0 * s + h1 * s_prev) >>> shadow[`DSP_ADDR_CHAN_SHIFT][3:0]) - seq[k + 2];
            e.flips[k] = (err_f * err_f < err * err);
            s_prev = s;
        end
        // History keeps the slicer decision, not the corrected one
        bit_prev = (s_prev > 0);
        hist[0]  = seq[4];
        hist[1]  = seq[5];
        e.bits   = e.bits ^ e.flips;
        return e;
    endfunction

    task automatic compare_flag(input string name, input logic exp_v, input logic act_v);
        if (act_v !== exp_v) begin
            $display("error: %s expected %h got %h", name, exp_v, act_v);
            value_errs_o = value_errs_o + 1;
        end
    endtask

    always @(posedge clk) begin
        cyc = cyc + 1;
        if (!rst_n_i) begin
            exp_q.delete();
            for (int a = 0; a < 64; a++) begin
                shadow[a] = '0;
            end
            shadow[`DSP_ADDR_W0] = 32'd1;
            shadow[`DSP_ADDR_H0] = 32'd1;
            hist[0]  = 0;
            hist[1]  = 0;
            bit_prev = 1'b0;
            count    = 0;
            bus_st   = AXS_IDLE;
        end else begin
            // Write wins over a read offered in the same cycle
            rd_free = (bus_st == AXS_IDLE) && !axil_req_i.awvalid && !axil_req_i.wvalid;
            wr_take = (bus_st == AXS_IDLE) && axil_req_i.awvalid && axil_req_i.wvalid;
            rd_take = rd_free && axil_req_i.arvalid;
            compare_flag("awready", wr_take, axil_rsp_i.awready);
            compare_flag("wready", wr_take, axil_rsp_i.wready);
            compare_flag("arready", rd_free, axil_rsp_i.arready);
            compare_flag("bvalid", bus_st == AXS_WRESP, axil_rsp_i.bvalid);
            compare_flag("rvalid", bus_st == AXS_RRESP, axil_rsp_i.rvalid);
            if (bus_st == AXS_RRESP && axil_req_i.rready &&
                axil_rsp_i.rdata !== rd_exp) begin
                $display("error: rdata expected %h got %h", rd_exp, axil_rsp_i.rdata);
                value_errs_o = value_errs_o + 1;
            end
            case (bus_st)
                AXS_IDLE: begin
                    if (wr_take) begin
                        bus_st = AXS_WRESP;
                    end else if (rd_take) begin
                        if (axil_req_i.araddr == `DSP_ADDR_FLIP_CNT) begin
                            rd_exp = count;
                        end else begin
                            rd_exp = shadow[axil_req_i.araddr];
                        end
                        bus_st = AXS_RRESP;
                    end
                end
                AXS_WRESP: begin
                    if (axil_req_i.bready) begin
                        bus_st = AXS_IDLE;
                    end
                end
                AXS_RRESP: begin
                    if (axil_req_i.rready) begin
                        bus_st = AXS_IDLE;
                    end
                end
                default: bus_st = AXS_IDLE;
            endcase

            if (bits_valid_i) begin
                if (exp_q.size() == 0) begin
                    $display("output word at cycle %0d has no matching input", cyc);
                    event_errs_o = event_errs_o + 1;
                end else begin
                    got = exp_q.pop_front();
                    if (got.due != cyc) begin
                        $display("output word came at cycle %0d, expected at %0d", cyc, got.due);
                        event_errs_o = event_errs_o + 1;
                    end
                    if (bits_i !== got.bits) begin
                        $display("error: bits_o expected %h got %h", got.bits, bits_i);
                        value_errs_o = value_errs_o + 1;
                    end
                    if (flips_i !== got.flips) begin
                        $display("error: flips_o expected %h got %h", got.flips, flips_i);
                        value_errs_o = value_errs_o + 1;
                    end
                    count = count + $countones(got.flips);
                    if (count > CNT_MAX) begin
                        count = CNT_MAX;
                    end
                end
            end
            while (exp_q.size() > 0 && exp_q[0].due <= cyc) begin
                $display("no output word for the input due at cycle %0d", exp_q[0].due);
                event_errs_o = event_errs_o + 1;
                void'(exp_q.pop_front());
            end

            if (codes_valid_i) begin
                exp_q.push_back(predict(codes_i));
            end

            // A clear in the same cycle as new flips wins
            if (wr_take) begin
                if (axil_req_i.awaddr == `DSP_ADDR_FLIP_CNT) begin
                    count = 0;
                end else begin
                    shadow[axil_req_i.awaddr] = axil_req_i.wdata & field_mask(axil_req_i.awaddr);
                end
            end
        end
        idle_o = (exp_q.size() == 0);
    end

endmodule

//--- tests/datapath_tb.sv
`timescale 1ns/1ps
`include "dsp_consts.svh"

module datapath_tb;
    import dsp_pkg::*;

    localparam int CLK_PERIOD   = 4;
    localparam int REG_OPS      = 40;
    localparam int CFG_ROUNDS   = 4;
    localparam int STREAM_WORDS = 400;
    // Worst case per bus transfer, including the stalled response
    localparam int BUS_CYCLES   = 12;
    localparam int BUS_OPS      = 40 + 2 * REG_OPS + 8 * CFG_ROUNDS;
    localparam int PLAN_CYCLES  = 16 + BUS_OPS * BUS_CYCLES
                                  + (CFG_ROUNDS + 2) * (STREAM_WORDS + 8);

    logic        clk;
    logic        rst_n;
    logic        codes_valid;
    lane_codes_t codes;
    axil_req_t   req;
    axil_rsp_t   rsp;
    logic        bits_valid;
    lane_bits_t  bits;
    lane_bits_t  flips;
    logic        chk_idle;
    int          value_errs;
    int          event_errs;
    logic [31:0] lfsr_q = 32'hf06c_04e8;

    datapath_core dut_i (
        .clk           (clk),
        .rst_n_i       (rst_n),
        .codes_valid_i (codes_valid),
        .codes_i       (codes),
        .axil_req_i    (req),
        .axil_rsp_o    (rsp),
        .bits_valid_o  (bits_valid),
        .bits_o        (bits),
        .flips_o       (flips)
    );

    datapath_checker checker_i (
        .clk           (clk),
        .rst_n_i       (rst_n),
        .codes_valid_i (codes_valid),
        .codes_i       (codes),
        .axil_req_i    (req),
        .axil_rsp_i    (rsp),
        .bits_valid_i  (bits_valid),
        .bits_i        (bits),
        .flips_i       (flips),
        .idle_o        (chk_idle),
        .value_errs_o  (value_errs),
        .event_errs_o  (event_errs)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Taps at bits 32, 22, 2 and 1
    function automatic logic lfsr_step();
        logic fb;
        fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
        lfsr_q = {lfsr_q[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_step()};
        end
        return r;
    endfunction

    task automatic write_reg(input logic [5:0] addr, input logic [31:0] data, input int stall);
        @(negedge clk);
        req.awvalid = 1'b1;
        req.awaddr  = addr;
        req.wvalid  = 1'b1;
        req.wdata   = data;
        do @(posedge clk); while (!rsp.awready);
        @(negedge clk);
        req.awvalid = 1'b0;
        req.wvalid  = 1'b0;
        repeat (stall) @(negedge clk);
        req.bready = 1'b1;
        do @(posedge clk); while (!rsp.bvalid);
        @(negedge clk);
        req.bready = 1'b0;
    endtask

    task automatic read_reg(input logic [5:0] addr);
        @(negedge clk);
        req.arvalid = 1'b1;
        req.araddr  = addr;
        do @(posedge clk); while (!rsp.arready);
        @(negedge clk);
        req.arvalid = 1'b0;
        req.rready  = 1'b1;
        do @(posedge clk); while (!rsp.rvalid);
        @(negedge clk);
        req.rready = 1'b0;
    endtask

    // Write and read to the same register offered in the same cycle
    task automatic write_then_read(input logic [5:0] addr, input logic [31:0] data);
        logic w_taken;
        logic r_taken;
        logic r_done;
        r_done = 1'b0;
        @(negedge clk);
        req.awvalid = 1'b1;
        req.awaddr  = addr;
        req.wvalid  = 1'b1;
        req.wdata   = data;
        req.arvalid = 1'b1;
        req.araddr  = addr;
        req.bready  = 1'b1;
        req.rready  = 1'b1;
        while (!r_done) begin
            @(posedge clk);
            w_taken = rsp.awready;
            r_taken = rsp.arready;
            r_done  = rsp.rvalid;
            @(negedge clk);
            if (w_taken) begin
                req.awvalid = 1'b0;
                req.wvalid  = 1'b0;
            end
            if (r_taken) begin
                req.arvalid = 1'b0;
            end
        end
        req.bready = 1'b0;
        req.rready = 1'b0;
    endtask

    task automatic load_config(input logic rnd);
        write_reg(`DSP_ADDR_W0, rnd ? random_bits(8) : 32'd1, 0);
        write_reg(`DSP_ADDR_W1, rnd ? random_bits(8) : 32'd0, 0);
        write_reg(`DSP_ADDR_W2, rnd ? random_bits(8) : 32'd0, 0);
        write_reg(`DSP_ADDR_FFE_SHIFT, rnd ? random_bits(2) + 32'd5 : 32'd0, 0);
        write_reg(`DSP_ADDR_THRESH, rnd ? random_bits(7) - 32'd64 : 32'd0, 0);
        write_reg(`DSP_ADDR_H0, rnd ? random_bits(8) : 32'd1, 0);
        write_reg(`DSP_ADDR_H1, rnd ? random_bits(8) : 32'd0, 0);
        write_reg(`DSP_ADDR_CHAN_SHIFT, rnd ? random_bits(2) : 32'd0, 0);
    endtask

    // About three words in four are valid
    task automatic send_words(input int n);
        repeat (n) begin
            @(negedge clk);
            codes_valid = (random_bits(2) != 0);
            codes       = random_bits(32);
        end
        @(negedge clk);
        codes_valid = 1'b0;
    endtask

    task automatic wait_drain();
        do @(negedge clk); while (!chk_idle);
    endtask

    initial begin
        #(CLK_PERIOD * PLAN_CYCLES * 2);
        $display("timeout: run did not finish within %0d cycles", PLAN_CYCLES * 2);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        logic [5:0] addr;
        clk         = 1'b0;
        rst_n       = 1'b0;
        codes_valid = 1'b0;
        codes       = '0;
        req         = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        for (int a = 0; a <= 'h24; a += 4) begin
            read_reg(6'(a));
        end
        repeat (8) @(negedge clk);

        repeat (REG_OPS) begin
            // Config registers sit at word offsets 0x00 to 0x1C
            addr = 6'(random_bits(3) << 2);
            write_reg(addr, random_bits(32), 0);
            read_reg(addr);
        end
        write_reg(`DSP_ADDR_THRESH, random_bits(32), 6);
        read_reg(`DSP_ADDR_THRESH);
        write_then_read(`DSP_ADDR_H1, random_bits(32));
        repeat (4) read_reg(6'(random_bits(6)));

        load_config(1'b0);
        send_words(STREAM_WORDS);
        wait_drain();
        read_reg(`DSP_ADDR_FLIP_CNT);

        repeat (CFG_ROUNDS) begin
            load_config(1'b1);
            send_words(STREAM_WORDS);
            wait_drain();
        end

        read_reg(`DSP_ADDR_FLIP_CNT);
        write_reg(`DSP_ADDR_FLIP_CNT, random_bits(32), 0);
        read_reg(`DSP_ADDR_FLIP_CNT);
        send_words(STREAM_WORDS);
        wait_drain();
        read_reg(`DSP_ADDR_FLIP_CNT);

        repeat (4) @(negedge clk);
        $display("checks done: %0d value errors, %0d other errors", value_errs, event_errs);
        if (value_errs == 0 && event_errs == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- sources.f
+incdir+logic
logic/dsp_pkg.sv
logic/cfg_axil_slave.sv
logic/ffe_slicer.sv
logic/channel_error.sv
logic/error_detector.sv
logic/flip_counter.sv
logic/datapath_core.sv
tests/datapath_checker.sv
tests/datapath_tb.sv
